// ==== hw/blur_config.svh ====
`ifndef BLUR_CONFIG_SVH
`define BLUR_CONFIG_SVH

// pixel width in bits
`define BLUR_PIX_W 8

// image height in rows
`define BLUR_IMG_ROWS 8

// strips across one image row
`define BLUR_STRIPS 4

// output pixels per strip
`define BLUR_STRIP_PIX 4

// extra pixels on each side of a strip window
// also the number of rows above and below the centre row
`define BLUR_HALO 2

// row index width
`define BLUR_ROW_AW 3

// strip index width
`define BLUR_STRIP_AW 2

`endif

// ==== hw/blur_pkg.sv ====
`include "blur_config.svh"

package blur_pkg;

  typedef logic [`BLUR_PIX_W-1:0] pix_t;

  // pixel 0 is the left-most pixel and sits in the top bits
  typedef pix_t [0:`BLUR_STRIPS*`BLUR_STRIP_PIX-1] img_row_t;

  // one strip of filter results
  typedef pix_t [0:`BLUR_STRIP_PIX-1] strip_t;

  // strip plus halo on both sides
  typedef pix_t [0:`BLUR_STRIP_PIX+2*`BLUR_HALO-1] win_row_t;

  // window rows, entry 0 is the top row
  typedef win_row_t [0:2*`BLUR_HALO] win_t;

  typedef logic [`BLUR_ROW_AW-1:0] row_idx_t;
  typedef logic [`BLUR_STRIP_AW-1:0] strip_idx_t;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_PRIME = 2'd1,
    ST_ROWS  = 2'd2,
    ST_DONE  = 2'd3
  } scan_state_t;

endpackage

// ==== hw/blur_scan_ctrl.sv ====
`timescale 1ns/10ps
`include "blur_config.svh"

module blur_scan_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic                 done,
  output logic                 img_rd,
  output blur_pkg::row_idx_t   img_addr,
  output logic                 pad_row,
  output blur_pkg::strip_idx_t strip_sel,
  output blur_pkg::row_idx_t   ctr_row,
  output logic                 ctr_valid,
  output logic                 win_clear
);
  import blur_pkg::*;

  scan_state_t state;
  // step within a strip, reused as drain counter in ST_DONE
  logic [3:0]  step_cnt;
  logic [3:0]  ctr_off;
  strip_idx_t  strip_cnt;
  logic        last_step;
  logic        last_strip;
  logic        drain_end;

  assign last_step  = (step_cnt == 4'(`BLUR_IMG_ROWS + 1));
  assign last_strip = (strip_cnt == strip_idx_t'(`BLUR_STRIPS - 1));

  // last write leaves the writer five cycles after the last step
  assign drain_end = (step_cnt == 4'd4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      step_cnt  <= '0;
      strip_cnt <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          step_cnt  <= '0;
          strip_cnt <= '0;
          if (start) begin
            state <= ST_PRIME;
          end
        end
        // rows 0 and 1 go in before the first output row
        ST_PRIME: begin
          step_cnt <= step_cnt + 4'd1;
          if (step_cnt == 4'd1) begin
            state <= ST_ROWS;
          end
        end
        ST_ROWS: begin
          if (last_step) begin
            step_cnt <= '0;
            if (last_strip) begin
              state <= ST_DONE;
            end else begin
              strip_cnt <= strip_cnt + 1'b1;
              state     <= ST_PRIME;
            end
          end else begin
            step_cnt <= step_cnt + 4'd1;
          end
        end
        ST_DONE: begin
          if (!done) begin
            if (drain_end) begin
              done <= 1'b1;
            end else begin
              step_cnt <= step_cnt + 4'd1;
            end
          end else if (!start) begin
            // host dropped start, close the handshake
            done  <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // reads for the image rows, zero rows for the last two steps
  assign img_rd   = (state == ST_PRIME) ||
                    ((state == ST_ROWS) && (step_cnt < 4'(`BLUR_IMG_ROWS)));
  assign pad_row  = (state == ST_ROWS) && (step_cnt >= 4'(`BLUR_IMG_ROWS));
  assign img_addr = step_cnt[`BLUR_ROW_AW-1:0];

  assign win_clear = (state == ST_PRIME) && (step_cnt == 4'd0);
  assign strip_sel = strip_cnt;

  // centre row trails the row just read by two
  assign ctr_valid = (state == ST_ROWS);
  assign ctr_off   = step_cnt - 4'd2;
  assign ctr_row   = ctr_off[`BLUR_ROW_AW-1:0];

endmodule

// ==== hw/gauss_3x3.sv ====
`timescale 1ns/10ps
`include "blur_config.svh"

module gauss_3x3 (
  input  logic             clk,
  input  logic             rst_n,
  input  blur_pkg::win_t   win,
  output blur_pkg::strip_t blur3
);
  import blur_pkg::*;

  // only the inner halo column on each side is needed
  logic [9:0]  col_sum [`BLUR_HALO-1:`BLUR_STRIP_PIX+`BLUR_HALO];
  logic [11:0] acc     [0:`BLUR_STRIP_PIX-1];
  strip_t      blur3_nxt;

  always_comb begin
    // vertical 1-2-1 over the three middle rows
    for (int c = `BLUR_HALO - 1; c <= `BLUR_STRIP_PIX + `BLUR_HALO; c++) begin
      col_sum[c] = 10'(win[`BLUR_HALO-1][c]) +
                   (10'(win[`BLUR_HALO][c]) << 1) +
                   10'(win[`BLUR_HALO+1][c]);
    end

    // horizontal 1-2-1, weights add up to 16
    for (int i = 0; i < `BLUR_STRIP_PIX; i++) begin
      acc[i] = 12'(col_sum[i+`BLUR_HALO-1]) +
               (12'(col_sum[i+`BLUR_HALO]) << 1) +
               12'(col_sum[i+`BLUR_HALO+1]);
      blur3_nxt[i] = acc[i][11:4];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur3 <= '0;
    end else begin
      blur3 <= blur3_nxt;
    end
  end

endmodule

// ==== hw/gauss_5x5.sv ====
`timescale 1ns/10ps
`include "blur_config.svh"

module gauss_5x5 (
  input  logic             clk,
  input  logic             rst_n,
  input  blur_pkg::win_t   win,
  output blur_pkg::strip_t blur5
);
  import blur_pkg::*;

  // 1-4-6-4-1 by shifts and adds, 6x is 4x plus 2x
  function automatic logic [15:0] tap_14641(input logic [15:0] a, b, c, d, e);
    return a + (b << 2) + (c << 2) + (c << 1) + (d << 2) + e;
  endfunction

  logic [11:0] col_sum [0:`BLUR_STRIP_PIX+2*`BLUR_HALO-1];
  logic [11:0] col_q   [0:`BLUR_STRIP_PIX+2*`BLUR_HALO-1];
  logic [15:0] acc     [0:`BLUR_STRIP_PIX-1];
  strip_t      blur5_nxt;

  // stage one, vertical sums for every window column
  // largest sum is 16 * 255 and fits in 12 bits
  always_comb begin
    for (int c = 0; c < `BLUR_STRIP_PIX + 2*`BLUR_HALO; c++) begin
      col_sum[c] = 12'(tap_14641(16'(win[0][c]),
                                 16'(win[1][c]),
                                 16'(win[2][c]),
                                 16'(win[3][c]),
                                 16'(win[4][c])));
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < `BLUR_STRIP_PIX + 2*`BLUR_HALO; c++) begin
      col_q[c] <= col_sum[c];
    end
  end

  // stage two, horizontal sums, weights add up to 256
  always_comb begin
    for (int i = 0; i < `BLUR_STRIP_PIX; i++) begin
      acc[i] = tap_14641(16'(col_q[i]),
                         16'(col_q[i+1]),
                         16'(col_q[i+2]),
                         16'(col_q[i+3]),
                         16'(col_q[i+4]));
      blur5_nxt[i] = acc[i][15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur5 <= '0;
    end else begin
      blur5 <= blur5_nxt;
    end
  end

endmodule

// ==== hw/gauss_blur_top.sv ====
`timescale 1ns/10ps

module gauss_blur_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  blur_pkg::img_row_t   img_data,
  output logic                 done,
  output blur_pkg::row_idx_t   img_addr,
  output logic                 out_we,
  output blur_pkg::row_idx_t   out_row,
  output blur_pkg::strip_idx_t out_strip,
  output blur_pkg::strip_t     out_blur3,
  output blur_pkg::strip_t     out_blur5
);

  logic                 img_rd;
  logic                 pad_row;
  logic                 win_clear;
  logic                 ctr_valid;
  blur_pkg::strip_idx_t strip_sel;
  blur_pkg::row_idx_t   ctr_row;

  blur_pkg::win_t       win;
  logic                 win_valid;
  blur_pkg::row_idx_t   win_row;
  blur_pkg::strip_idx_t win_strip;

  blur_pkg::strip_t     blur3;
  blur_pkg::strip_t     blur5;

  blur_scan_ctrl i_scan_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_rd    (img_rd),
    .img_addr  (img_addr),
    .pad_row   (pad_row),
    .strip_sel (strip_sel),
    .ctr_row   (ctr_row),
    .ctr_valid (ctr_valid),
    .win_clear (win_clear)
  );

  row_window i_row_window (
    .clk       (clk),
    .rst_n     (rst_n),
    .img_rd    (img_rd),
    .pad_row   (pad_row),
    .win_clear (win_clear),
    .img_data  (img_data),
    .strip_sel (strip_sel),
    .ctr_row   (ctr_row),
    .ctr_valid (ctr_valid),
    .win       (win),
    .win_valid (win_valid),
    .win_row   (win_row),
    .win_strip (win_strip)
  );

  gauss_3x3 i_gauss_3x3 (
    .clk   (clk),
    .rst_n (rst_n),
    .win   (win),
    .blur3 (blur3)
  );

  gauss_5x5 i_gauss_5x5 (
    .clk   (clk),
    .rst_n (rst_n),
    .win   (win),
    .blur5 (blur5)
  );

  result_writer i_result_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .blur3     (blur3),
    .blur5     (blur5),
    .win_valid (win_valid),
    .win_row   (win_row),
    .win_strip (win_strip),
    .out_we    (out_we),
    .out_row   (out_row),
    .out_strip (out_strip),
    .out_blur3 (out_blur3),
    .out_blur5 (out_blur5)
  );

endmodule

// ==== hw/result_writer.sv ====
`timescale 1ns/10ps

module result_writer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blur_pkg::strip_t     blur3,
  input  blur_pkg::strip_t     blur5,
  input  logic                 win_valid,
  input  blur_pkg::row_idx_t   win_row,
  input  blur_pkg::strip_idx_t win_strip,
  output logic                 out_we,
  output blur_pkg::row_idx_t   out_row,
  output blur_pkg::strip_idx_t out_strip,
  output blur_pkg::strip_t     out_blur3,
  output blur_pkg::strip_t     out_blur5
);
  import blur_pkg::*;

  // 3x3 result is one cycle ahead of the 5x5 one
  strip_t     blur3_q;
  logic       vld_q1;
  logic       vld_q2;
  row_idx_t   row_q1;
  row_idx_t   row_q2;
  strip_idx_t strip_q1;
  strip_idx_t strip_q2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q1 <= 1'b0;
      vld_q2 <= 1'b0;
      out_we <= 1'b0;
    end else begin
      vld_q1 <= win_valid;
      vld_q2 <= vld_q1;
      out_we <= vld_q2;
    end
  end

  // tags need two cycles to meet the 5x5 result
  always_ff @(posedge clk) begin
    blur3_q  <= blur3;
    row_q1   <= win_row;
    row_q2   <= row_q1;
    strip_q1 <= win_strip;
    strip_q2 <= strip_q1;
  end

  // one write per strip row with both blurs
  always_ff @(posedge clk) begin
    out_row   <= row_q2;
    out_strip <= strip_q2;
    out_blur3 <= blur3_q;
    out_blur5 <= blur5;
  end

endmodule

// ==== hw/row_window.sv ====
`timescale 1ns/10ps
`include "blur_config.svh"

module row_window (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 img_rd,
  input  logic                 pad_row,
  input  logic                 win_clear,
  input  blur_pkg::img_row_t   img_data,
  input  blur_pkg::strip_idx_t strip_sel,
  input  blur_pkg::row_idx_t   ctr_row,
  input  logic                 ctr_valid,
  output blur_pkg::win_t       win,
  output logic                 win_valid,
  output blur_pkg::row_idx_t   win_row,
  output blur_pkg::strip_idx_t win_strip
);
  import blur_pkg::*;

  // full image rows, entry 0 is the oldest
  img_row_t   rows [0:2*`BLUR_HALO];
  logic       shift_q;
  logic       pad_q;
  logic       clr_q;
  logic       vld_q;
  strip_idx_t strip_q;
  row_idx_t   row_q;

  // step controls wait one cycle for the memory data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= 1'b0;
      pad_q   <= 1'b0;
      clr_q   <= 1'b0;
      vld_q   <= 1'b0;
    end else begin
      shift_q <= img_rd || pad_row;
      pad_q   <= pad_row;
      clr_q   <= win_clear;
      vld_q   <= ctr_valid;
    end
  end

  always_ff @(posedge clk) begin
    strip_q <= strip_sel;
    row_q   <= ctr_row;
  end

  // shift buffer, new row enters at the bottom
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r <= 2*`BLUR_HALO; r++) begin
        rows[r] <= '0;
      end
    end else if (shift_q) begin
      for (int r = 0; r < 2*`BLUR_HALO; r++) begin
        rows[r] <= clr_q ? '0 : rows[r+1];
      end
      rows[2*`BLUR_HALO] <= pad_q ? '0 : img_data;
    end
  end

  // tags move with the buffer contents
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= vld_q;
    end
  end

  always_ff @(posedge clk) begin
    win_row   <= row_q;
    win_strip <= strip_q;
  end

  // zero halo past the left and right image edges
  always_comb begin
    pix_t [0:`BLUR_STRIPS*`BLUR_STRIP_PIX+2*`BLUR_HALO-1] ext_row;
    for (int r = 0; r <= 2*`BLUR_HALO; r++) begin
      ext_row = {{`BLUR_HALO*`BLUR_PIX_W{1'b0}}, rows[r], {`BLUR_HALO*`BLUR_PIX_W{1'b0}}};
      win[r]  = ext_row[win_strip*`BLUR_STRIP_PIX +: `BLUR_STRIP_PIX+2*`BLUR_HALO];
    end
  end

endmodule

// ==== sources.f ====
+incdir+hw
+incdir+tests
hw/blur_pkg.sv
hw/blur_scan_ctrl.sv
hw/row_window.sv
hw/gauss_3x3.sv
hw/gauss_5x5.sv
hw/result_writer.sv
hw/gauss_blur_top.sv
tests/tb_gauss_blur.sv

// ==== tests/tb_blur_model.svh ====
`ifndef TB_BLUR_MODEL_SVH
`define TB_BLUR_MODEL_SVH

localparam int IMG_ROWS = `BLUR_IMG_ROWS;
localparam int IMG_COLS = `BLUR_STRIPS * `BLUR_STRIP_PIX;

typedef enum {IMG_ZERO, IMG_CONST, IMG_IMPULSE, IMG_RANDOM} img_kind_t;

// image held by the memory model, row by row
pix_t img [0:IMG_ROWS-1][0:IMG_COLS-1];

logic [31:0] lcg_state = 32'h74d5_7f0a;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// pixels past the image edge read as zero
function automatic int pix_at(input int r, input int c);
  if (r < 0 || r >= IMG_ROWS || c < 0 || c >= IMG_COLS) begin
    return 0;
  end
  return int'(img[r][c]);
endfunction

// binomial taps, k counts from the left end of the kernel
function automatic int kernel_w(input int size, input int k);
  int w3 [0:2];
  int w5 [0:4];
  w3 = '{1, 2, 1};
  w5 = '{1, 4, 6, 4, 1};
  return (size == 3) ? w3[k] : w5[k];
endfunction

// full 2d weighted sum, then truncating divide by the weight total
function automatic pix_t ref_blur(input int size, input int r, input int c);
  int half;
  int sum;
  int total;
  half  = size / 2;
  sum   = 0;
  total = (size == 3) ? 16 : 256;
  for (int dr = -half; dr <= half; dr++) begin
    for (int dc = -half; dc <= half; dc++) begin
      sum += kernel_w(size, dr + half) * kernel_w(size, dc + half) * pix_at(r + dr, c + dc);
    end
  end
  return pix_t'(sum / total);
endfunction

// whole row as the memory returns it
function automatic img_row_t image_row(input row_idx_t r);
  img_row_t row;
  for (int c = 0; c < IMG_COLS; c++) begin
    row[c] = img[r][c];
  end
  return row;
endfunction

task automatic make_image(input img_kind_t kind);
  for (int r = 0; r < IMG_ROWS; r++) begin
    for (int c = 0; c < IMG_COLS; c++) begin
      case (kind)
        IMG_ZERO: img[r][c] = '0;
        IMG_CONST: img[r][c] = 8'd100;
        // impulse sits near a strip edge so the halo gets used
        IMG_IMPULSE: img[r][c] = (r == 3 && c == 6) ? 8'd255 : 8'd0;
        default: begin
          lcg_state = lcg_next(lcg_state);
          img[r][c] = lcg_state[23:16];
        end
      endcase
    end
  end
endtask

`endif

// ==== tests/tb_gauss_blur.sv ====
`timescale 1ns/10ps
`include "blur_config.svh"

module tb_gauss_blur;
  import blur_pkg::*;

  `include "tb_blur_model.svh"

  localparam int NUM_CASES  = 7;
  localparam int WAIT_LIMIT = 500;
  localparam int HOLD_CYC   = 3;

  logic       clk;
  logic       rst_n;
  logic       start;
  img_row_t   img_data;
  logic       done;
  row_idx_t   img_addr;
  logic       out_we;
  row_idx_t   out_row;
  strip_idx_t out_strip;
  strip_t     out_blur3;
  strip_t     out_blur5;

  int err_cnt;
  int pass_tests;
  int fail_tests;
  bit hung;

  // image kind plus fresh or rerun flag and write count of each case
  img_kind_t case_kind   [0:NUM_CASES-1] = '{IMG_ZERO, IMG_CONST, IMG_IMPULSE,
                                             IMG_RANDOM, IMG_RANDOM, IMG_RANDOM,
                                             IMG_RANDOM};
  bit        case_fresh  [0:NUM_CASES-1] = '{1, 1, 1, 1, 1, 1, 0};
  int        case_writes [0:NUM_CASES-1] = '{32, 32, 32, 32, 32, 32, 32};

  gauss_blur_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .img_data  (img_data),
    .done      (done),
    .img_addr  (img_addr),
    .out_we    (out_we),
    .out_row   (out_row),
    .out_strip (out_strip),
    .out_blur3 (out_blur3),
    .out_blur5 (out_blur5)
  );

  initial begin
    clk = 1'b0;
  end

  always begin
    #20 clk = ~clk;
  end

  // row memory answers one cycle after the address
  always @(posedge clk) begin
    img_data <= image_row(img_addr);
  end

  task automatic check_pix(input pix_t got, input pix_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input row_idx_t got_row, input strip_idx_t got_strip,
                           input row_idx_t exp_row, input strip_idx_t exp_strip);
    if (got_row !== exp_row || got_strip !== exp_strip) begin
      err_cnt++;
      $display("ERR %0t: write at strip %0d row %0d, expected strip %0d row %0d",
               $time, got_strip, got_row, exp_strip, exp_row);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      err_cnt++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic run_case(input int t);
    int         cyc;
    int         writes;
    int         errs_before;
    int         col;
    logic       seen_done;
    row_idx_t   exp_row;
    strip_idx_t exp_strip;
    errs_before = err_cnt;
    writes      = 0;
    cyc         = 0;
    seen_done   = 1'b0;
    exp_row     = '0;
    exp_strip   = '0;
    @(posedge clk);
    start <= 1'b1;
    // writes come strip by strip with rows top to bottom
    while (!seen_done && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      cyc++;
      if (out_we) begin
        check_flag(done, 1'b0, "done during a write");
        check_idx(out_row, out_strip, exp_row, exp_strip);
        for (int i = 0; i < `BLUR_STRIP_PIX; i++) begin
          col = int'(exp_strip) * `BLUR_STRIP_PIX + i;
          check_pix(out_blur3[i], ref_blur(3, int'(exp_row), col),
                    $sformatf("blur3 row %0d col %0d", exp_row, col));
          check_pix(out_blur5[i], ref_blur(5, int'(exp_row), col),
                    $sformatf("blur5 row %0d col %0d", exp_row, col));
        end
        writes++;
        if (exp_row == row_idx_t'(IMG_ROWS - 1)) begin
          exp_strip++;
        end
        exp_row++;
      end
      seen_done = done;
    end
    if (!seen_done) begin
      $display("test %0d: timeout, done did not rise within %0d cycles", t, WAIT_LIMIT);
      fail_tests++;
      hung = 1'b1;
      return;
    end
    check_count(writes, case_writes[t], "writes before done");
    // done must hold while start is still high
    for (int k = 0; k < HOLD_CYC; k++) begin
      @(negedge clk);
      check_flag(done, 1'b1, "done while start held");
      check_flag(out_we, 1'b0, "out_we after done");
    end
    @(posedge clk);
    start <= 1'b0;
    cyc = 0;
    while (seen_done && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      cyc++;
      seen_done = done;
    end
    if (seen_done) begin
      $display("test %0d: timeout, done did not fall after start was dropped", t);
      fail_tests++;
      hung = 1'b1;
      return;
    end
    if (err_cnt == errs_before) begin
      pass_tests++;
    end else begin
      fail_tests++;
    end
    $display("test %0d %s: %0d writes, %0d errors", t, case_kind[t].name(), writes,
             err_cnt - errs_before);
  endtask

  initial begin
    err_cnt    = 0;
    pass_tests = 0;
    fail_tests = 0;
    hung       = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    img_data   = '0;
    make_image(IMG_ZERO);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag(done, 1'b0, "done after reset");
    check_flag(out_we, 1'b0, "out_we after reset");
    for (int t = 0; t < NUM_CASES && !hung; t++) begin
      if (case_fresh[t]) begin
        make_image(case_kind[t]);
      end
      run_case(t);
    end
    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
    if (err_cnt == 0 && !hung) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
